// ==== src/rsv_pkg.sv ====
package rsv_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------

    // Entry count and the width of an entry index
    localparam int RSV_DEPTH     = 16;
    localparam int RSV_IDX_WIDTH = 4;

    // Dispatch slots per cycle, also the number of issue read ports
    localparam int DSP_PORTS = 4;

    // ------------------------------
    // Payload field widths
    // ------------------------------

    localparam int ROB_ID_WIDTH    = 6;
    localparam int DECINFO_WIDTH   = 16;
    localparam int PRF_CODE_WIDTH  = 6;
    localparam int IMM_WIDTH       = 32;
    localparam int EXCP_CODE_WIDTH = 5;

    // ------------------------------
    // Types
    // ------------------------------

    // Payload held by one reservation station entry
    typedef struct packed {
        logic [ROB_ID_WIDTH-1:0]    rob_id;
        logic [DECINFO_WIDTH-1:0]   decinfo;
        logic                       dst_vld;
        logic [PRF_CODE_WIDTH-1:0]  prf_code;
        // Set for a compressed instruction
        logic                       rvc;
        logic [IMM_WIDTH-1:0]       imm;
        logic [EXCP_CODE_WIDTH-1:0] excp_code;
    } rsv_entry_t;

    // One dispatch slot, with the entry it targets
    typedef struct packed {
        logic                     vld;
        logic [RSV_IDX_WIDTH-1:0] free_entry;
        rsv_entry_t               payload;
    } rsv_dsp_t;

    // One-hot pick of the oldest ready entry for an issue port
    typedef logic [RSV_DEPTH-1:0] rsv_oldest_t;

endpackage

// ==== src/rsv_dsp_write.sv ====
`timescale 1ns/1ns

module rsv_dsp_write (
    input  logic                                            i_csr_trap_flush,
    input  logic                                            i_exu_mis_flush,
    input  logic                                            i_exu_ls_flush,

    input  rsv_pkg::rsv_dsp_t   [rsv_pkg::DSP_PORTS-1:0]    i_dsp,

    output logic                [rsv_pkg::RSV_DEPTH-1:0]    o_wr_ena,
    output rsv_pkg::rsv_entry_t [rsv_pkg::RSV_DEPTH-1:0]    o_wr_data
);

    logic                           need_flush;
    logic [rsv_pkg::DSP_PORTS-1:0]  slot_vld;

    // Any flush source kills the whole dispatch group
    assign need_flush = i_csr_trap_flush | i_exu_mis_flush | i_exu_ls_flush;

    always_comb begin
        for (int p = 0; p < rsv_pkg::DSP_PORTS; p++) begin
            slot_vld[p] = i_dsp[p].vld;
        end
    end

    // ------------------------------
    // Per-entry decode
    // ------------------------------

    for (genvar e = 0; e < rsv_pkg::RSV_DEPTH; e++) begin : g_entry
        localparam logic [rsv_pkg::RSV_IDX_WIDTH-1:0] ENTRY_IDX = e;

        logic [rsv_pkg::DSP_PORTS-1:0] hit;
        rsv_pkg::rsv_entry_t           merged;

        // Slots naming the same entry merge by OR, valid or not
        always_comb begin
            merged = '0;
            for (int p = 0; p < rsv_pkg::DSP_PORTS; p++) begin
                hit[p] = (i_dsp[p].free_entry == ENTRY_IDX);
                if (hit[p]) begin
                    merged = merged | i_dsp[p].payload;
                end
            end
        end

        // Only a valid slot opens the entry for writing
        assign o_wr_ena[e]  = (|(hit & slot_vld)) & ~need_flush;
        assign o_wr_data[e] = merged;
    end

endmodule

// ==== src/rsv_entry_array.sv ====
`timescale 1ns/1ns

module rsv_entry_array (
    input  logic                                            clk,
    input  logic                                            i_rst_n,

    input  logic                [rsv_pkg::RSV_DEPTH-1:0]    i_wr_ena,
    input  rsv_pkg::rsv_entry_t [rsv_pkg::RSV_DEPTH-1:0]    i_wr_data,

    output rsv_pkg::rsv_entry_t [rsv_pkg::RSV_DEPTH-1:0]    o_entries
);

    rsv_pkg::rsv_entry_t [rsv_pkg::RSV_DEPTH-1:0] entry_q;

    // ------------------------------
    // Payload registers
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            entry_q <= '0;
        end else begin
            for (int e = 0; e < rsv_pkg::RSV_DEPTH; e++) begin
                if (i_wr_ena[e]) begin
                    entry_q[e] <= i_wr_data[e];
                end
            end
        end
    end

    // Issue ports read the registers directly
    assign o_entries = entry_q;

endmodule

// ==== src/rsv_issue_read.sv ====
`timescale 1ns/1ns

module rsv_issue_read (
    input  rsv_pkg::rsv_entry_t [rsv_pkg::RSV_DEPTH-1:0]    i_entries,
    input  rsv_pkg::rsv_oldest_t                            i_oldest,
    output rsv_pkg::rsv_entry_t                             o_entry
);

    logic [rsv_pkg::RSV_IDX_WIDTH-1:0]  enc_idx;
    logic [rsv_pkg::RSV_IDX_WIDTH-1:0]  sel_idx;
    logic                               is_onehot;

    // ------------------------------
    // One-hot to index
    // ------------------------------

    // OR of the indices of all set bits, exact when one-hot
    always_comb begin
        enc_idx = '0;
        for (int i = 0; i < rsv_pkg::RSV_DEPTH; i++) begin
            if (i_oldest[i]) begin
                enc_idx = enc_idx | i[rsv_pkg::RSV_IDX_WIDTH-1:0];
            end
        end
    end

    // Nonzero with no second bit set
    assign is_onehot = (i_oldest != '0) && ((i_oldest & (i_oldest - 1'b1)) == '0);

    // Empty or multi-hot selects fall back to entry 0
    assign sel_idx = is_onehot ? enc_idx : '0;

    // ------------------------------
    // Entry mux
    // ------------------------------

    assign o_entry = i_entries[sel_idx];

endmodule

// ==== src/rsv_data_top.sv ====
`timescale 1ns/1ns

module rsv_data_top (
    input  logic                                                clk,
    input  logic                                                i_rst_n,

    input  logic                                                i_csr_trap_flush,
    input  logic                                                i_exu_mis_flush,
    input  logic                                                i_exu_ls_flush,

    input  rsv_pkg::rsv_dsp_t       [rsv_pkg::DSP_PORTS-1:0]    i_dsp,

    input  rsv_pkg::rsv_oldest_t    [rsv_pkg::DSP_PORTS-1:0]    i_oldest,
    output rsv_pkg::rsv_entry_t     [rsv_pkg::DSP_PORTS-1:0]    o_rsv_entry
);

    logic                [rsv_pkg::RSV_DEPTH-1:0]   wr_ena;
    rsv_pkg::rsv_entry_t [rsv_pkg::RSV_DEPTH-1:0]   wr_data;
    rsv_pkg::rsv_entry_t [rsv_pkg::RSV_DEPTH-1:0]   entries;

    // ------------------------------
    // Dispatch write path
    // ------------------------------

    rsv_dsp_write u_dsp_write (
        .i_csr_trap_flush   (i_csr_trap_flush),
        .i_exu_mis_flush    (i_exu_mis_flush),
        .i_exu_ls_flush     (i_exu_ls_flush),
        .i_dsp              (i_dsp),
        .o_wr_ena           (wr_ena),
        .o_wr_data          (wr_data)
    );

    rsv_entry_array u_entry_array (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_wr_ena           (wr_ena),
        .i_wr_data          (wr_data),
        .o_entries          (entries)
    );

    // ------------------------------
    // Issue read ports
    // ------------------------------

    for (genvar k = 0; k < rsv_pkg::DSP_PORTS; k++) begin : g_issue
        rsv_issue_read u_issue_read (
            .i_entries      (entries),
            .i_oldest       (i_oldest[k]),
            .o_entry        (o_rsv_entry[k])
        );
    end

endmodule

// ==== include/rsv_tb_cases.svh ====
`ifndef RSV_TB_CASES_SVH
`define RSV_TB_CASES_SVH

// Columns: slot valids, free entries, payload seeds, flush {trap, mis, ls},
// oldest vectors and expected read seeds, highest slot or port first

typedef struct packed {
    logic [3:0]  vld;
    // Four 4-bit entry indices
    logic [15:0] entries;
    // Four 8-bit payload seeds
    logic [31:0] seeds;
    logic [2:0]  flush;
    // Four 16-bit one-hot selects
    logic [63:0] oldest;
    // Seed expected on each read port after the edge
    logic [31:0] expect_seeds;
} case_row_t;

localparam int CASE_COUNT = 12;

case_row_t case_table [CASE_COUNT] = '{
    // Fresh after reset, invalid slots must not land
    '{4'b0000, 16'h0000, 32'h1122_3344, 3'b000, 64'h0020_0100_8000_0001, 32'h0000_0000},
    // Four distinct entries in one cycle
    '{4'b1111, 16'h3210, 32'hA1B2_C3D4, 3'b000, 64'h0002_0008_0001_0004, 32'hC3A1_D4B2},
    '{4'b1111, 16'hC96F, 32'h5A3C_7E18, 3'b000, 64'h0200_0040_8000_1000, 32'h3C7E_185A},
    // Each flush source on its own
    '{4'b1111, 16'h3210, 32'hFFFF_FFFF, 3'b100, 64'h0002_0008_0001_0004, 32'hC3A1_D4B2},
    '{4'b1111, 16'hC96F, 32'h0102_0408, 3'b010, 64'h0200_0040_8000_1000, 32'h3C7E_185A},
    '{4'b0011, 16'h5431, 32'h9999_9999, 3'b001, 64'h0020_0010_0008_0002, 32'h0000_A1C3},
    // Two slots into entry 7
    '{4'b0011, 16'hBA77, 32'hFFFF_0F30, 3'b000, 64'h0080_0800_0400_0080, 32'h3F00_003F},
    // Three slots into entry 13
    '{4'b0111, 16'hEDDD, 32'h7781_4224, 3'b000, 64'h0001_0080_4000_2000, 32'hD43F_00E7},
    // Rewrite of entry 0, empty and multi-hot selects
    '{4'b0001, 16'hA850, 32'hEEEE_EE66, 3'b000, 64'h0004_8001_0003_0000, 32'hB266_6666},
    '{4'b0000, 16'h0000, 32'h0000_0000, 3'b000, 64'h0240_0000_1000_FFFF, 32'h6666_5A66},
    // Merge blocked by all flushes, then let through
    '{4'b0011, 16'h2188, 32'h0000_F00F, 3'b111, 64'h8000_2000_0200_0100, 32'h18E7_3C00},
    '{4'b0011, 16'h2188, 32'h0000_F00F, 3'b000, 64'h8000_2000_0200_0100, 32'h18E7_3CFF}
};

`endif

// ==== test/tb_rsv_data.sv ====
`timescale 1ns/1ns

module tb_rsv_data;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 8;
    localparam int RANDOM_CYCLES = 200;

    `include "rsv_tb_cases.svh"

    localparam longint WATCHDOG_NS =
        longint'(CASE_COUNT + RANDOM_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;

    logic clk = 1'b0;
    logic i_rst_n;
    logic i_csr_trap_flush;
    logic i_exu_mis_flush;
    logic i_exu_ls_flush;

    rsv_pkg::rsv_dsp_t    [rsv_pkg::DSP_PORTS-1:0] i_dsp;
    rsv_pkg::rsv_oldest_t [rsv_pkg::DSP_PORTS-1:0] i_oldest;
    rsv_pkg::rsv_entry_t  [rsv_pkg::DSP_PORTS-1:0] o_rsv_entry;

    // Shadow copy of the entry array
    rsv_pkg::rsv_entry_t model_q [rsv_pkg::RSV_DEPTH];

    int          model_errors;
    int          table_errors;

    rsv_data_top dut_i (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_csr_trap_flush   (i_csr_trap_flush),
        .i_exu_mis_flush    (i_exu_mis_flush),
        .i_exu_ls_flush     (i_exu_ls_flush),
        .i_dsp              (i_dsp),
        .i_oldest           (i_oldest),
        .o_rsv_entry        (o_rsv_entry)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------
    // Helpers
    // ------------------------------

    // Seed spread over the whole payload so OR of seeds gives OR of payloads
    function automatic rsv_pkg::rsv_entry_t seed_payload(input logic [7:0] seed);
        logic [71:0] spread;
        spread = {9{seed}};
        return rsv_pkg::rsv_entry_t'(spread[$bits(rsv_pkg::rsv_entry_t)-1:0]);
    endfunction

    // Picks entry 0 unless exactly one bit of the select is set
    function automatic int pick_index(input rsv_pkg::rsv_oldest_t oldest);
        int idx;
        idx = 0;
        if ($countones(oldest) == 1) begin
            for (int i = 0; i < rsv_pkg::RSV_DEPTH; i++) begin
                if (oldest[i]) begin
                    idx = i;
                end
            end
        end
        return idx;
    endfunction

    task automatic drive_idle;
        i_csr_trap_flush = 1'b0;
        i_exu_mis_flush  = 1'b0;
        i_exu_ls_flush   = 1'b0;
        i_dsp            = '0;
        i_oldest         = '0;
    endtask

    task automatic drive_row(input case_row_t row);
        for (int p = 0; p < rsv_pkg::DSP_PORTS; p++) begin
            i_dsp[p].vld        = row.vld[p];
            i_dsp[p].free_entry = row.entries[p*4 +: 4];
            i_dsp[p].payload    = seed_payload(row.seeds[p*8 +: 8]);
        end
        {i_csr_trap_flush, i_exu_mis_flush, i_exu_ls_flush} = row.flush;
        for (int k = 0; k < rsv_pkg::DSP_PORTS; k++) begin
            i_oldest[k] = row.oldest[k*16 +: 16];
        end
    endtask

    // Distinct entries per cycle, random payloads, rare flushes
    task automatic drive_random;
        logic [rsv_pkg::RSV_DEPTH-1:0] used;
        logic [95:0]                   noise;
        int                            pick;
        used = '0;
        for (int p = 0; p < rsv_pkg::DSP_PORTS; p++) begin
            pick = int'($urandom_range(rsv_pkg::RSV_DEPTH - 1, 0));
            while (used[pick]) begin
                pick = (pick + 1) % rsv_pkg::RSV_DEPTH;
            end
            used[pick] = 1'b1;
            noise = {$urandom, $urandom, $urandom};
            i_dsp[p].vld        = ($urandom_range(3, 0) != 0);
            i_dsp[p].free_entry = pick[3:0];
            i_dsp[p].payload    =
                rsv_pkg::rsv_entry_t'(noise[$bits(rsv_pkg::rsv_entry_t)-1:0]);
        end
        i_csr_trap_flush = 1'b0;
        i_exu_mis_flush  = 1'b0;
        i_exu_ls_flush   = 1'b0;
        if ($urandom_range(5, 0) == 0) begin
            case ($urandom_range(2, 0))
                0:       i_csr_trap_flush = 1'b1;
                1:       i_exu_mis_flush  = 1'b1;
                default: i_exu_ls_flush   = 1'b1;
            endcase
        end
        for (int k = 0; k < rsv_pkg::DSP_PORTS; k++) begin
            i_oldest[k] = rsv_pkg::rsv_oldest_t'(1) << $urandom_range(15, 0);
        end
    endtask

    // Applied right after a rising edge with the inputs that edge sampled
    task automatic update_model;
        rsv_pkg::rsv_entry_t next_val;
        logic                hit_vld;
        if (!i_rst_n) begin
            for (int e = 0; e < rsv_pkg::RSV_DEPTH; e++) begin
                model_q[e] = '0;
            end
        end else if (!(i_csr_trap_flush || i_exu_mis_flush || i_exu_ls_flush)) begin
            for (int e = 0; e < rsv_pkg::RSV_DEPTH; e++) begin
                next_val = '0;
                hit_vld  = 1'b0;
                for (int p = 0; p < rsv_pkg::DSP_PORTS; p++) begin
                    if (int'(i_dsp[p].free_entry) == e) begin
                        next_val = next_val | i_dsp[p].payload;
                        hit_vld  = hit_vld | i_dsp[p].vld;
                    end
                end
                if (hit_vld) begin
                    model_q[e] = next_val;
                end
            end
        end
    endtask

    task automatic cycle_step;
        @(posedge clk);
        update_model();
        @(negedge clk);
    endtask

    task automatic check_outputs(input bit use_table, input int row,
                                 input logic [31:0] expect_seeds);
        rsv_pkg::rsv_entry_t want;
        for (int k = 0; k < rsv_pkg::DSP_PORTS; k++) begin
            want = model_q[pick_index(i_oldest[k])];
            if (o_rsv_entry[k] !== want) begin
                model_errors++;
                $display("error t=%0t o_rsv_entry[%0d] expected %h actual %h",
                         $time, k, want, o_rsv_entry[k]);
            end
            if (use_table) begin
                want = seed_payload(expect_seeds[k*8 +: 8]);
                if (o_rsv_entry[k] !== want) begin
                    table_errors++;
                    $display("error t=%0t row %0d o_rsv_entry[%0d] expected %h actual %h",
                             $time, row, k, want, o_rsv_entry[k]);
                end
            end
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        void'($urandom(32'h4cae_fa91));
        model_errors = 0;
        table_errors = 0;
        i_rst_n      = 1'b0;
        drive_idle();
        for (int e = 0; e < rsv_pkg::RSV_DEPTH; e++) begin
            model_q[e] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        check_outputs(1'b0, 0, '0);

        for (int r = 0; r < CASE_COUNT; r++) begin
            drive_row(case_table[r]);
            cycle_step();
            check_outputs(1'b1, r, case_table[r].expect_seeds);
        end

        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            drive_random();
            cycle_step();
            check_outputs(1'b0, c, '0);
        end

        $display("summary: %0d model mismatches, %0d table mismatches",
                 model_errors, table_errors);
        if (model_errors + table_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // ------------------------------
    // Watchdog
    // ------------------------------

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
src/rsv_pkg.sv
src/rsv_dsp_write.sv
src/rsv_entry_array.sv
src/rsv_issue_read.sv
src/rsv_data_top.sv
test/tb_rsv_data.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the reservation station payload testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_rsv_data
OBJ_DIR=obj_dir
LOG_FILE=sim.log

# Build the simulation executable from the file list
verilator --binary -Wno-fatal \
    --top-module "$TOP" \
    -Mdir "$OBJ_DIR" \
    -o "V$TOP" \
    -f tb.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

# Run and keep the log for the verdict
"./$OBJ_DIR/V$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# The verdict line must stand alone in the log
if grep -qx '\*\* PASS \*\*' "$LOG_FILE"; then
    echo "result: passed"
    exit 0
else
    echo "result: failed, see $LOG_FILE"
    exit 1
fi
